/* common/lc3b_types.sv */
package lc3b_types;

	// the LC-3b is a 16-bit machine with eight general registers.
	localparam int word_w = 16;
	localparam int reg_w = 3;
	localparam int op_w = 4;
	localparam int num_regs = 8;

	typedef logic [word_w-1:0] lc3b_word;
	typedef logic [reg_w-1:0] lc3b_reg;

	// opcode encodings follow the LC-3b ISA.
	typedef enum logic [op_w-1:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// the low five bits of ADD and AND hold either a register or an immediate.
	typedef union packed {
		logic [4:0] imm5;
		struct packed {
			logic [1:0] unused;
			lc3b_reg sr2;
		} rs;
	} lc3b_alu_src_u;

	typedef union packed {
		struct packed {
			lc3b_opcode opcode;
			lc3b_reg dr;
			lc3b_reg sr1;
			logic imm_flag;
			lc3b_alu_src_u src;
		} alu;
		struct packed {
			lc3b_opcode opcode;
			lc3b_reg sr;
			lc3b_reg base;
			logic [5:0] offset6;
		} st;
		struct packed {
			lc3b_opcode opcode;
			lc3b_reg dr;
			lc3b_reg sr1;
			// a selects arithmetic right shift, d selects a right shift.
			logic a;
			logic d;
			logic [3:0] amount4;
		} shf;
	} lc3b_instr_u;

endpackage : lc3b_types

/* common/id_ex_if.sv */
`timescale 1ns/1ns

interface id_ex_if;
	import lc3b_types::*;

	logic valid;
	lc3b_instr_u ir;
	// operand values as read in decode, before any forwarding.
	lc3b_word sr1_val;
	lc3b_word sr2_val;
	lc3b_word st_val;

	modport id
	(
		output valid, ir, sr1_val, sr2_val, st_val
	);

	modport ex
	(
		input valid, ir, sr1_val, sr2_val, st_val
	);

endinterface : id_ex_if

/* common/fwd_if.sv */
`timescale 1ns/1ns

interface fwd_if;
	import lc3b_types::*;

	// result held in the EX_MEM latch.
	logic ex_mem_we;
	lc3b_reg ex_mem_dest;
	lc3b_word ex_mem_val;

	// result held in the MEM_WB latch, which is also the register write port.
	logic mem_wb_we;
	lc3b_reg mem_wb_dest;
	lc3b_word mem_wb_val;

	modport ex
	(
		output ex_mem_we, ex_mem_dest, ex_mem_val,
		input mem_wb_we, mem_wb_dest, mem_wb_val
	);

	modport wb
	(
		output mem_wb_we, mem_wb_dest, mem_wb_val
	);

	modport rf
	(
		input mem_wb_we, mem_wb_dest, mem_wb_val
	);

endinterface : fwd_if

/* execute/forwarding_logic.sv */
`timescale 1ns/1ns

module forwarding_logic
(
	input lc3b_types::lc3b_instr_u ir,
	fwd_if.ex fwd,
	output logic sr1_fwd_sel,
	output logic sr1_from_wb,
	output logic sr2_fwd_sel,
	output logic sr2_from_wb,
	output logic st_fwd_sel,
	output logic st_from_wb
);

	import lc3b_types::*;

	lc3b_opcode opcode;
	logic uses_sr1;
	logic uses_sr2;
	logic uses_st;

	// returns {forward, from_wb}. EX_MEM is younger, so it is checked first.
	function automatic logic [1:0] fwd_check(input lc3b_reg src, input logic used);
		logic [1:0] sel;
		sel = 2'b00;
		if (used && fwd.ex_mem_we && (fwd.ex_mem_dest == src))
		begin
			sel = 2'b10;
		end
		else if (used && fwd.mem_wb_we && (fwd.mem_wb_dest == src))
		begin
			sel = 2'b11;
		end
		return sel;
	endfunction

	assign opcode = ir.alu.opcode;

	// stores read sr1 as their base register.
	assign uses_sr1 = (opcode == op_add) || (opcode == op_and) || (opcode == op_not)
		|| (opcode == op_shf) || (opcode == op_stb) || (opcode == op_str)
		|| (opcode == op_sti);

	assign uses_sr2 = ((opcode == op_add) || (opcode == op_and)) && !ir.alu.imm_flag;

	assign uses_st = (opcode == op_stb) || (opcode == op_str) || (opcode == op_sti);

	always_comb
	begin
		{sr1_fwd_sel, sr1_from_wb} = fwd_check(ir.alu.sr1, uses_sr1);
		{sr2_fwd_sel, sr2_from_wb} = fwd_check(ir.alu.src.rs.sr2, uses_sr2);
		{st_fwd_sel, st_from_wb} = fwd_check(ir.st.sr, uses_st);
	end

endmodule : forwarding_logic

/* execute/alu.sv */
`timescale 1ns/1ns

module alu
(
	input lc3b_types::lc3b_instr_u ir,
	input lc3b_types::lc3b_word a,
	input lc3b_types::lc3b_word b,
	output lc3b_types::lc3b_word result,
	output logic writes
);

	import lc3b_types::*;

	lc3b_word operand2;
	lc3b_word offset;

	// second operand is either sr2 or the sign-extended imm5.
	assign operand2 = ir.alu.imm_flag ? {{(word_w-5){ir.alu.src.imm5[4]}}, ir.alu.src.imm5} : b;
	assign offset = {{(word_w-6){ir.st.offset6[5]}}, ir.st.offset6};

	always_comb
	begin
		result = '0;
		writes = 1'b0;
		case (ir.alu.opcode)
			op_add:
			begin
				result = a + operand2;
				writes = 1'b1;
			end
			op_and:
			begin
				result = a & operand2;
				writes = 1'b1;
			end
			op_not:
			begin
				result = ~a;
				writes = 1'b1;
			end
			op_shf:
			begin
				if (!ir.shf.d)
					result = a << ir.shf.amount4;
				else if (!ir.shf.a)
					result = a >> ir.shf.amount4;
				else
					result = $signed(a) >>> ir.shf.amount4;
				writes = 1'b1;
			end
			// word stores scale the offset, byte stores do not.
			op_str, op_sti: result = a + (offset << 1);
			op_stb: result = a + offset;
			default: result = '0;
		endcase
	end

endmodule : alu

/* execute/ex_stage.sv */
`timescale 1ns/1ns

module ex_stage
(
	input logic clk,
	input logic rst_n,
	id_ex_if.ex id,
	fwd_if.ex fwd,
	output logic store_valid,
	output lc3b_types::lc3b_opcode store_op,
	output lc3b_types::lc3b_word store_addr,
	output lc3b_types::lc3b_word store_data
);

	import lc3b_types::*;

	logic sr1_fwd_sel;
	logic sr1_from_wb;
	logic sr2_fwd_sel;
	logic sr2_from_wb;
	logic st_fwd_sel;
	logic st_from_wb;
	lc3b_word op_a;
	lc3b_word op_b;
	lc3b_word st_data;
	lc3b_word result;
	logic writes;
	logic is_store;

	forwarding_logic u_fwd
	(
		.ir(id.ir),
		.fwd(fwd),
		.sr1_fwd_sel(sr1_fwd_sel),
		.sr1_from_wb(sr1_from_wb),
		.sr2_fwd_sel(sr2_fwd_sel),
		.sr2_from_wb(sr2_from_wb),
		.st_fwd_sel(st_fwd_sel),
		.st_from_wb(st_from_wb)
	);

	// each operand comes from the decode latch unless a later stage holds a newer value.
	assign op_a = !sr1_fwd_sel ? id.sr1_val : (sr1_from_wb ? fwd.mem_wb_val : fwd.ex_mem_val);
	assign op_b = !sr2_fwd_sel ? id.sr2_val : (sr2_from_wb ? fwd.mem_wb_val : fwd.ex_mem_val);
	assign st_data = !st_fwd_sel ? id.st_val : (st_from_wb ? fwd.mem_wb_val : fwd.ex_mem_val);

	alu u_alu
	(
		.ir(id.ir),
		.a(op_a),
		.b(op_b),
		.result(result),
		.writes(writes)
	);

	assign is_store = (id.ir.st.opcode == op_str) || (id.ir.st.opcode == op_stb)
		|| (id.ir.st.opcode == op_sti);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fwd.ex_mem_we <= 1'b0;
			store_valid <= 1'b0;
		end
		else
		begin
			fwd.ex_mem_we <= id.valid && writes;
			store_valid <= id.valid && is_store;
		end
	end

	always_ff @(posedge clk)
	begin
		fwd.ex_mem_dest <= id.ir.alu.dr;
		fwd.ex_mem_val <= result;
		store_op <= id.ir.st.opcode;
		// for a store the ALU result is the effective address.
		store_addr <= result;
		store_data <= st_data;
	end

endmodule : ex_stage

/* src/id_stage.sv */
`timescale 1ns/1ns

module id_stage
(
	input logic clk,
	input logic rst_n,
	input logic ir_valid,
	input lc3b_types::lc3b_word ir,
	fwd_if.rf rf,
	id_ex_if.id id
);

	import lc3b_types::*;

	lc3b_word regs [num_regs];
	lc3b_instr_u dec;
	lc3b_word sr1_rd;
	lc3b_word sr2_rd;
	lc3b_word st_rd;

	// a read of the register being written this cycle sees the new value.
	function automatic lc3b_word rf_read(input lc3b_reg idx);
		lc3b_word val;
		if (rf.mem_wb_we && (rf.mem_wb_dest == idx))
		begin
			val = rf.mem_wb_val;
		end
		else
		begin
			val = regs[idx];
		end
		return val;
	endfunction

	assign dec = ir;

	// sr1 shares its bit position with the shift source and the store base.
	always_comb
	begin
		sr1_rd = rf_read(dec.alu.sr1);
		sr2_rd = rf_read(dec.alu.src.rs.sr2);
		st_rd = rf_read(dec.st.sr);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < num_regs; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (rf.mem_wb_we)
		begin
			regs[rf.mem_wb_dest] <= rf.mem_wb_val;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			id.valid <= 1'b0;
		end
		else
		begin
			id.valid <= ir_valid;
		end
	end

	// the decoded word and its operands move into execute alongside valid.
	always_ff @(posedge clk)
	begin
		id.ir <= dec;
		id.sr1_val <= sr1_rd;
		id.sr2_val <= sr2_rd;
		id.st_val <= st_rd;
	end

endmodule : id_stage

/* src/mem_wb_stage.sv */
`timescale 1ns/1ns

module mem_wb_stage
(
	input logic clk,
	input logic rst_n,
	fwd_if.wb fwd,
	input logic ex_mem_we,
	input lc3b_types::lc3b_reg ex_mem_dest,
	input lc3b_types::lc3b_word ex_mem_val,
	output logic wb_valid,
	output lc3b_types::lc3b_reg wb_dest,
	output lc3b_types::lc3b_word wb_val
);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fwd.mem_wb_we <= 1'b0;
		end
		else
		begin
			fwd.mem_wb_we <= ex_mem_we;
		end
	end

	always_ff @(posedge clk)
	begin
		fwd.mem_wb_dest <= ex_mem_dest;
		fwd.mem_wb_val <= ex_mem_val;
	end

	// the latch drives the register write port and retires the result in the same cycle.
	assign wb_valid = fwd.mem_wb_we;
	assign wb_dest = fwd.mem_wb_dest;
	assign wb_val = fwd.mem_wb_val;

endmodule : mem_wb_stage

/* src/lc3b_pipe_top.sv */
`timescale 1ns/1ns

module lc3b_pipe_top
(
	input logic clk,
	input logic rst_n,
	input logic ir_valid,
	input lc3b_types::lc3b_word ir,
	output logic store_valid,
	output lc3b_types::lc3b_opcode store_op,
	output lc3b_types::lc3b_word store_addr,
	output lc3b_types::lc3b_word store_data,
	output logic wb_valid,
	output lc3b_types::lc3b_reg wb_dest,
	output lc3b_types::lc3b_word wb_val
);

	id_ex_if u_id_ex ();
	fwd_if u_fwd_bus ();

	id_stage u_id
	(
		.clk(clk),
		.rst_n(rst_n),
		.ir_valid(ir_valid),
		.ir(ir),
		.rf(u_fwd_bus.rf),
		.id(u_id_ex.id)
	);

	ex_stage u_ex
	(
		.clk(clk),
		.rst_n(rst_n),
		.id(u_id_ex.ex),
		.fwd(u_fwd_bus.ex),
		.store_valid(store_valid),
		.store_op(store_op),
		.store_addr(store_addr),
		.store_data(store_data)
	);

	// the EX_MEM result reaches writeback as plain signals taken off the bus.
	mem_wb_stage u_wb
	(
		.clk(clk),
		.rst_n(rst_n),
		.fwd(u_fwd_bus.wb),
		.ex_mem_we(u_fwd_bus.ex_mem_we),
		.ex_mem_dest(u_fwd_bus.ex_mem_dest),
		.ex_mem_val(u_fwd_bus.ex_mem_val),
		.wb_valid(wb_valid),
		.wb_dest(wb_dest),
		.wb_val(wb_val)
	);

endmodule : lc3b_pipe_top

/* sim/lc3b_pipe_tb.sv */
`timescale 1ns/1ns

module lc3b_pipe_tb;

	import lc3b_types::*;

	localparam int num_tests = 6;
	localparam int drain_limit = 50;

	logic clk;
	logic rst_n;
	logic ir_valid;
	lc3b_word ir;
	logic store_valid;
	lc3b_opcode store_op;
	lc3b_word store_addr;
	lc3b_word store_data;
	logic wb_valid;
	lc3b_reg wb_dest;
	lc3b_word wb_val;

	// stimulus table, one row per instruction, tagged with the test it belongs to.
	lc3b_word tbl_word [$];
	int tbl_test [$];
	string test_name [num_tests];

	// reference registers and the results the DUT still owes, oldest first.
	lc3b_word model_regs [num_regs];
	logic [18:0] wb_q [$];
	logic [35:0] st_q [$];
	logic [18:0] exp_wb;
	logic [35:0] exp_st;

	integer seed;
	int errors;
	int tests_failed;
	int wb_seen;
	int st_seen;
	int wb_issued;
	int st_issued;
	logic timed_out;

	lc3b_pipe_top UUT
	(
		.clk(clk),
		.rst_n(rst_n),
		.ir_valid(ir_valid),
		.ir(ir),
		.store_valid(store_valid),
		.store_op(store_op),
		.store_addr(store_addr),
		.store_data(store_data),
		.wb_valid(wb_valid),
		.wb_dest(wb_dest),
		.wb_val(wb_val)
	);

	always #5 clk = ~clk;

	function automatic lc3b_word reg_form(input lc3b_opcode op, input int dr, input int sr1,
		input int sr2);
		return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
	endfunction

	function automatic lc3b_word imm_form(input lc3b_opcode op, input int dr, input int sr1,
		input int imm);
		return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
	endfunction

	function automatic lc3b_word not_instr(input int dr, input int sr);
		return {op_not, 3'(dr), 3'(sr), 6'b111111};
	endfunction

	// mode is {A, D}: 0 is LSHF, 1 is RSHFL and 3 is RSHFA.
	function automatic lc3b_word shift_instr(input int dr, input int sr, input int mode,
		input int amt);
		return {op_shf, 3'(dr), 3'(sr), 2'(mode), 4'(amt)};
	endfunction

	function automatic lc3b_word store_instr(input lc3b_opcode op, input int sr, input int base,
		input int off);
		return {op, 3'(sr), 3'(base), 6'(off)};
	endfunction

	// copies bit (bits-1) of v into every bit above it.
	function automatic lc3b_word sext(input lc3b_word v, input int bits);
		lc3b_word r;
		r = v;
		for (int i = bits; i < 16; i++)
		begin
			r[i] = v[bits-1];
		end
		return r;
	endfunction

	task automatic add_row(input int test, input lc3b_word w);
		tbl_test.push_back(test);
		tbl_word.push_back(w);
	endtask

	task automatic push_wb(input logic [2:0] dest, input lc3b_word val);
		wb_q.push_back({dest, val});
		model_regs[dest] = val;
		wb_issued++;
	endtask

	// executes one instruction in program order and records what the DUT must show.
	task automatic model_step(input lc3b_word w);
		logic [3:0] op;
		lc3b_word a;
		lc3b_word b;
		lc3b_word addr;
		int amt;
		op = w[15:12];
		a = model_regs[w[8:6]];
		b = w[5] ? sext(w, 5) : model_regs[w[2:0]];
		amt = w[3:0];
		case (op)
			4'd1: push_wb(w[11:9], a + b);
			4'd5: push_wb(w[11:9], a & b);
			4'd9: push_wb(w[11:9], ~a);
			4'd13:
			begin
				case (w[5:4])
					2'b01: push_wb(w[11:9], a >> amt);
					2'b11: push_wb(w[11:9], $unsigned($signed(a) >>> amt));
					default: push_wb(w[11:9], a << amt);
				endcase
			end
			4'd3, 4'd7, 4'd11:
			begin
				addr = (op == 4'd3) ? a + sext(w, 6) : a + (sext(w, 6) << 1);
				st_q.push_back({op, addr, model_regs[w[11:9]]});
				st_issued++;
			end
			default:
			begin
			end
		endcase
	endtask

	task automatic add_random(input int test, input int count);
		int kind;
		int dr;
		int sr1;
		int sr2;
		int imm;
		int m;
		for (int i = 0; i < count; i++)
		begin
			kind = {$random(seed)} % 8;
			dr = {$random(seed)} % 8;
			sr1 = {$random(seed)} % 8;
			sr2 = {$random(seed)} % 8;
			imm = $random(seed);
			m = {$random(seed)} % 3;
			case (kind)
				0: add_row(test, reg_form(op_add, dr, sr1, sr2));
				1: add_row(test, imm_form(op_add, dr, sr1, imm));
				2: add_row(test, reg_form(op_and, dr, sr1, sr2));
				3: add_row(test, imm_form(op_and, dr, sr1, imm));
				4: add_row(test, not_instr(dr, sr1));
				5: add_row(test, shift_instr(dr, sr1, (m == 2) ? 3 : m, imm));
				6: add_row(test, store_instr(op_str, dr, sr1, imm));
				default:
				begin
					if (m == 0)
						add_row(test, store_instr(op_stb, dr, sr1, imm));
					else
						add_row(test, store_instr(op_sti, dr, sr1, imm));
				end
			endcase
		end
	endtask

	task automatic build_table();
		test_name[0] = "store after reset";
		add_row(0, store_instr(op_str, 0, 0, 0));
		test_name[1] = "back-to-back forwarding";
		add_row(1, imm_form(op_add, 1, 0, 5));
		add_row(1, reg_form(op_add, 2, 1, 1));
		add_row(1, imm_form(op_add, 3, 0, -3));
		add_row(1, reg_form(op_and, 4, 3, 3));
		test_name[2] = "distance two and three";
		add_row(2, imm_form(op_add, 5, 0, 7));
		add_row(2, imm_form(op_add, 6, 0, 1));
		add_row(2, reg_form(op_add, 7, 5, 0));
		add_row(2, reg_form(op_add, 1, 5, 5));
		add_row(2, imm_form(op_add, 2, 0, 4));
		add_row(2, imm_form(op_add, 2, 0, 9));
		add_row(2, reg_form(op_add, 3, 2, 0));
		test_name[3] = "not and shifts";
		add_row(3, imm_form(op_add, 1, 0, -16));
		add_row(3, not_instr(2, 1));
		add_row(3, shift_instr(3, 1, 0, 3));
		add_row(3, shift_instr(4, 1, 1, 2));
		add_row(3, shift_instr(5, 1, 3, 4));
		add_row(3, shift_instr(6, 2, 3, 1));
		test_name[4] = "stores with forwarding";
		add_row(4, imm_form(op_add, 1, 0, 10));
		add_row(4, imm_form(op_add, 2, 0, -7));
		add_row(4, store_instr(op_str, 2, 1, 3));
		add_row(4, store_instr(op_stb, 2, 1, -2));
		add_row(4, imm_form(op_add, 3, 0, 12));
		add_row(4, store_instr(op_sti, 3, 3, -1));
		test_name[5] = "random run";
		add_random(5, 200);
	endtask

	// waits until every expected pulse has been seen, then a few quiet cycles.
	task automatic drain(output logic late);
		int cycles;
		cycles = 0;
		while ((wb_q.size() != 0 || st_q.size() != 0) && cycles < drain_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		late = (wb_q.size() != 0) || (st_q.size() != 0);
		for (int i = 0; i < 3; i++)
		begin
			@(posedge clk);
		end
	endtask

	always @(negedge clk)
	begin
		if (rst_n && wb_valid === 1'b1)
		begin
			wb_seen++;
			exp_wb = (wb_q.size() != 0) ? wb_q.pop_front() : 'x;
			assert (wb_dest === exp_wb[18:16] && wb_val === exp_wb[15:0])
			else
			begin
				errors++;
				$display("[FAIL] %0t: wb R%0d = %h, expected R%0d = %h", $time, wb_dest, wb_val,
					exp_wb[18:16], exp_wb[15:0]);
			end
		end
		if (rst_n && store_valid === 1'b1)
		begin
			st_seen++;
			exp_st = (st_q.size() != 0) ? st_q.pop_front() : 'x;
			assert (store_op === exp_st[35:32] && store_addr === exp_st[31:16]
				&& store_data === exp_st[15:0])
			else
			begin
				errors++;
				$display("[FAIL] %0t: store op %h addr %h data %h, expected op %h addr %h data %h",
					$time, store_op, store_addr, store_data, exp_st[35:32], exp_st[31:16],
					exp_st[15:0]);
			end
		end
	end

	initial
	begin
		int err_start;
		int wb_start;
		int st_start;
		int wbi_start;
		int sti_start;
		logic late;
		clk = 1'b0;
		rst_n = 1'b0;
		ir_valid = 1'b0;
		ir = '0;
		seed = 86520;
		errors = 0;
		tests_failed = 0;
		wb_seen = 0;
		st_seen = 0;
		wb_issued = 0;
		st_issued = 0;
		timed_out = 1'b0;
		for (int i = 0; i < num_regs; i++)
		begin
			model_regs[i] = '0;
		end
		build_table();
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int t = 0; t < num_tests && !timed_out; t++)
		begin
			err_start = errors;
			wb_start = wb_seen;
			st_start = st_seen;
			wbi_start = wb_issued;
			sti_start = st_issued;
			for (int i = 0; i < tbl_word.size(); i++)
			begin
				if (tbl_test[i] == t)
				begin
					@(posedge clk);
					#1;
					ir_valid = 1'b1;
					ir = tbl_word[i];
					model_step(tbl_word[i]);
				end
			end
			@(posedge clk);
			#1;
			ir_valid = 1'b0;
			ir = '0;
			drain(late);
			if (late)
			begin
				timed_out = 1'b1;
				$display("timeout in test %0d: %0d wb and %0d store results never arrived", t,
					wb_q.size(), st_q.size());
			end
			assert (wb_seen - wb_start == wb_issued - wbi_start)
			else
			begin
				errors++;
				$display("[FAIL] %0t: %0d wb pulses for %0d writing instructions", $time,
					wb_seen - wb_start, wb_issued - wbi_start);
			end
			assert (st_seen - st_start == st_issued - sti_start)
			else
			begin
				errors++;
				$display("[FAIL] %0t: %0d store pulses for %0d stores", $time,
					st_seen - st_start, st_issued - sti_start);
			end
			if (errors == err_start && !late)
			begin
				$display("test %0d %s: ok", t, test_name[t]);
			end
			else
			begin
				tests_failed++;
				$display("test %0d %s: %0d errors", t, test_name[t], errors - err_start);
			end
		end
		$display("tests failed %0d of %0d, wb pulses %0d, store pulses %0d, errors %0d",
			tests_failed, num_tests, wb_seen, st_seen, errors);
		if (errors == 0 && !timed_out)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule : lc3b_pipe_tb

/* lc3b_pipe.f */
common/lc3b_types.sv
common/id_ex_if.sv
common/fwd_if.sv
execute/forwarding_logic.sv
execute/alu.sv
execute/ex_stage.sv
src/id_stage.sv
src/mem_wb_stage.sv
src/lc3b_pipe_top.sv
sim/lc3b_pipe_tb.sv
